// ==== Bender.yml ====
package:
  name: rt_top

sources:
  - hw/rt_pkg.sv
  - hw/scene_buffer.sv
  - hw/scene_apb_port.sv
  - hw/ray_intersector.sv
  - hw/ray_reflector.sv
  - hw/ray_tracer.sv
  - hw/rt_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_rt_top.sv

// ==== hw/ray_intersector.sv ====
`timescale 1ns/1ps
`default_nettype none

module ray_intersector
  import rt_pkg::*;
#(
  parameter int MAX_OBJS = MAX_OBJS_DEF
) (
  input logic clk,
  input logic rst,
  input logic start,
  input vec3_t origin,
  input dvec3_t dir,
  input obj_cnt_t num_objs,
  output logic b_req,
  output waddr_t b_addr,
  input logic b_gnt,
  input word_t rdata,
  output logic hit_valid,
  output logic hit_any,
  output sphere_t hit_obj
);
  typedef enum logic [2:0] {S_IDLE, S_REQ, S_DATA, S_TEST, S_DONE} state_t;

  state_t state;
  obj_cnt_t idx;
  logic [1:0] word;
  vec3_t org;
  dvec3_t dvec;
  sphere_t cur;
  sphere_t best;
  logic found;
  logic signed [47:0] best_ll;
  logic signed [10:0] lx;
  logic signed [10:0] ly;
  logic signed [10:0] lz;
  logic signed [7:0] dx;
  logic signed [7:0] dy;
  logic signed [7:0] dz;
  logic signed [8:0] rad;
  logic signed [47:0] b;
  logic signed [47:0] dd;
  logic signed [47:0] ll;
  logic signed [47:0] lhs;
  logic signed [47:0] rhs;
  logic hit;
  logic last;

  // L = centre - origin, one extra bit keeps the difference exact
  assign lx = {cur.center.x[9], cur.center.x} - {org.x[9], org.x};
  assign ly = {cur.center.y[9], cur.center.y} - {org.y[9], org.y};
  assign lz = {cur.center.z[9], cur.center.z} - {org.z[9], org.z};
  assign dx = dvec.x;
  assign dy = dvec.y;
  assign dz = dvec.z;
  assign rad = {1'b0, cur.radius};

  assign b = lx * dx + ly * dy + lz * dz;
  assign dd = dx * dx + dy * dy + dz * dz;
  assign ll = lx * lx + ly * ly + lz * lz;
  // Distance from centre to the ray line, scaled by |D|^2 to avoid a divide
  assign lhs = ll * dd - b * b;
  assign rhs = rad * rad * dd;
  assign hit = (b > 0) && (lhs <= rhs);
  assign last = (idx == num_objs - 1'b1) || (idx == obj_cnt_t'(MAX_OBJS - 1));

  assign b_req = (state == S_REQ);
  assign b_addr = obj_addr(idx, word);
  assign hit_valid = (state == S_DONE);
  assign hit_any = found;
  assign hit_obj = best;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= S_IDLE;
      idx <= '0;
      word <= W_CENTER;
      found <= 1'b0;
    end else begin
      case (state)
        S_IDLE: begin
          if (start) begin
            org <= origin;
            dvec <= dir;
            idx <= '0;
            word <= W_CENTER;
            found <= 1'b0;
            state <= (num_objs == '0) ? S_DONE : S_REQ;
          end
        end
        S_REQ: begin
          if (b_gnt) begin
            state <= S_DATA;
          end
        end
        S_DATA: begin
          case (word)
            W_CENTER: cur.center <= vec3_t'(rdata[29:0]);
            W_MAT: begin
              cur.radius <= rdata[31:24];
              cur.color <= rgb_t'(rdata[23:0]);
            end
            W_EMIT: cur.emit <= rgb_t'(rdata[23:0]);
          endcase
          if (word == 2'(WORDS_PER_OBJ - 1)) begin
            state <= S_TEST;
          end else begin
            word <= word + 1'b1;
            state <= S_REQ;
          end
        end
        S_TEST: begin
          // Strict compare keeps the lower index on a tie
          if (hit && (!found || ll < best_ll)) begin
            best <= cur;
            best_ll <= ll;
            found <= 1'b1;
          end
          if (last) begin
            state <= S_DONE;
          end else begin
            idx <= idx + 1'b1;
            word <= W_CENTER;
            state <= S_REQ;
          end
        end
        S_DONE: state <= S_IDLE;
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hw/ray_reflector.sv ====
`timescale 1ns/1ps
`default_nettype none

module ray_reflector
  import rt_pkg::*;
#(
  parameter logic [31:0] SCATTER_SEED = 32'h1d2c3b4a
) (
  input logic clk,
  input logic rst,
  input logic start,
  input rgb_t ray_color,
  input rgb_t light,
  input sphere_t hit_obj,
  output logic done,
  output rgb_t new_color,
  output rgb_t new_light,
  output vec3_t new_origin,
  output dvec3_t new_dir
);
  logic [31:0] rng;
  logic stage1;
  rgb_t tint;
  rgb_t glow;
  rgb_t light_r;

  // Channel product, 255 * 255 comes out as 254
  function automatic chan_t scale(chan_t a, chan_t b);
    logic [15:0] p;
    p = a * b;
    return p[15:8];
  endfunction

  function automatic rgb_t mul_rgb(rgb_t a, rgb_t b);
    rgb_t o;
    o.r = scale(a.r, b.r);
    o.g = scale(a.g, b.g);
    o.b = scale(a.b, b.b);
    return o;
  endfunction

  function automatic chan_t add_sat(chan_t a, chan_t b);
    logic [8:0] s;
    s = a + b;
    return s[8] ? 8'hff : s[7:0];
  endfunction

  function automatic logic [31:0] xorshift32(logic [31:0] s);
    logic [31:0] t;
    t = s ^ (s << 13);
    t = t ^ (t >> 17);
    t = t ^ (t << 5);
    return t;
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      rng <= SCATTER_SEED;
      stage1 <= 1'b0;
      done <= 1'b0;
    end else begin
      stage1 <= start;
      done <= stage1;
      if (start) begin
        rng <= xorshift32(rng);
      end
    end
  end

  // Stage 1 multiplies, stage 2 accumulates
  always_ff @(posedge clk) begin
    if (start) begin
      tint <= mul_rgb(ray_color, hit_obj.color);
      glow <= mul_rgb(ray_color, hit_obj.emit);
      light_r <= light;
      new_origin <= hit_obj.center;
    end
    if (stage1) begin
      new_color <= tint;
      new_light.r <= add_sat(light_r.r, glow.r);
      new_light.g <= add_sat(light_r.g, glow.g);
      new_light.b <= add_sat(light_r.b, glow.b);
    end
  end

  // Scatter direction straight from the advanced generator state
  assign new_dir.x = dir_t'(rng[7:0]);
  assign new_dir.y = dir_t'(rng[15:8]);
  assign new_dir.z = dir_t'(rng[23:16]);

endmodule

`default_nettype wire

// ==== hw/ray_tracer.sv ====
`timescale 1ns/1ps
`default_nettype none

module ray_tracer
  import rt_pkg::*;
#(
  parameter int MAX_OBJS = MAX_OBJS_DEF,
  parameter int MAX_BOUNCES = 4,
  parameter logic [31:0] SCATTER_SEED = 32'h1d2c3b4a
) (
  input logic clk,
  input logic rst,
  input ray_req_t ray_in,
  input logic ray_valid,
  output logic ray_ready,
  output ray_res_t res,
  output logic res_valid,
  input obj_cnt_t num_objs,
  output logic b_req,
  output waddr_t b_addr,
  input logic b_gnt,
  input word_t rdata
);
  localparam int BW = $clog2(MAX_BOUNCES + 1);

  typedef enum logic [1:0] {IDLE, INTX, REFLECT} state_t;

  state_t state;
  logic [BW-1:0] bounces;
  vec3_t cur_origin;
  dvec3_t cur_dir;
  rgb_t cur_color;
  rgb_t cur_light;
  pixel_t cur_pixel;
  logic intx_start;
  logic rflx_start;
  logic hit_valid;
  logic hit_any;
  sphere_t hit_obj;
  logic rflx_done;
  rgb_t rflx_color;
  rgb_t rflx_light;
  vec3_t rflx_origin;
  dvec3_t rflx_dir;

  assign ray_ready = (state == IDLE);

  // The result pulse goes out one cycle before the FSM drops back to IDLE
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
      bounces <= '0;
      intx_start <= 1'b0;
      rflx_start <= 1'b0;
      res_valid <= 1'b0;
    end else begin
      intx_start <= 1'b0;
      rflx_start <= 1'b0;
      res_valid <= 1'b0;
      case (state)
        IDLE: begin
          if (ray_valid) begin
            cur_origin <= ray_in.origin;
            cur_dir <= ray_in.dir;
            cur_pixel <= ray_in.pixel;
            cur_color <= '{r: 8'hff, g: 8'hff, b: 8'hff};
            cur_light <= '0;
            bounces <= '0;
            intx_start <= 1'b1;
            state <= INTX;
          end
        end
        INTX: begin
          if (res_valid) begin
            state <= IDLE;
          end else if (hit_valid) begin
            if (hit_any) begin
              rflx_start <= 1'b1;
              state <= REFLECT;
            end else begin
              // Miss, return what was gathered so far
              res <= '{pixel: cur_pixel, color: cur_light};
              res_valid <= 1'b1;
            end
          end
        end
        REFLECT: begin
          if (res_valid) begin
            state <= IDLE;
          end else if (rflx_done) begin
            cur_origin <= rflx_origin;
            cur_dir <= rflx_dir;
            cur_color <= rflx_color;
            cur_light <= rflx_light;
            if (bounces == BW'(MAX_BOUNCES - 1)) begin
              res <= '{pixel: cur_pixel, color: rflx_light};
              res_valid <= 1'b1;
            end else begin
              bounces <= bounces + 1'b1;
              intx_start <= 1'b1;
              state <= INTX;
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  ray_intersector #(
    .MAX_OBJS(MAX_OBJS)
  ) u_intersector (
    .clk(clk),
    .rst(rst),
    .start(intx_start),
    .origin(cur_origin),
    .dir(cur_dir),
    .num_objs(num_objs),
    .b_req(b_req),
    .b_addr(b_addr),
    .b_gnt(b_gnt),
    .rdata(rdata),
    .hit_valid(hit_valid),
    .hit_any(hit_any),
    .hit_obj(hit_obj)
  );

  ray_reflector #(
    .SCATTER_SEED(SCATTER_SEED)
  ) u_reflector (
    .clk(clk),
    .rst(rst),
    .start(rflx_start),
    .ray_color(cur_color),
    .light(cur_light),
    .hit_obj(hit_obj),
    .done(rflx_done),
    .new_color(rflx_color),
    .new_light(rflx_light),
    .new_origin(rflx_origin),
    .new_dir(rflx_dir)
  );

  res_not_ready: assert property (@(posedge clk) disable iff (rst) !(res_valid && ray_ready))
    else $error("result emitted while a new ray is accepted");

  // Intersector answers only a search this FSM is waiting on
  hit_in_intx: assert property (@(posedge clk) disable iff (rst) hit_valid |-> state == INTX)
    else $error("intersector result outside INTX");

endmodule

`default_nettype wire

// ==== hw/rt_pkg.sv ====
`default_nettype none

package rt_pkg;

  // Geometry is plain signed integer
  typedef logic signed [9:0] coord_t;
  typedef logic signed [7:0] dir_t;
  // 255 stands for full intensity
  typedef logic [7:0] chan_t;

  typedef logic [31:0] word_t;
  typedef logic [7:0] waddr_t;
  typedef logic [11:0] apb_addr_t;
  typedef logic [7:0] obj_cnt_t;

  typedef struct packed {
    coord_t x;
    coord_t y;
    coord_t z;
  } vec3_t;

  typedef struct packed {
    dir_t x;
    dir_t y;
    dir_t z;
  } dvec3_t;

  typedef struct packed {
    chan_t r;
    chan_t g;
    chan_t b;
  } rgb_t;

  typedef struct packed {
    logic [10:0] h;
    logic [9:0] v;
  } pixel_t;

  typedef struct packed {
    vec3_t origin;
    dvec3_t dir;
    pixel_t pixel;
  } ray_req_t;

  typedef struct packed {
    pixel_t pixel;
    rgb_t color;
  } ray_res_t;

  typedef struct packed {
    vec3_t center;
    logic [7:0] radius;
    rgb_t color;
    rgb_t emit;
  } sphere_t;

  localparam int MAX_OBJS_DEF = 16;
  localparam int WORDS_PER_OBJ = 3;

  // Four-word stride per sphere, the top word is spare
  localparam int OBJ_STRIDE_LOG2 = 2;
  localparam logic [1:0] W_CENTER = 2'd0;
  localparam logic [1:0] W_MAT = 2'd1;
  localparam logic [1:0] W_EMIT = 2'd2;
  localparam apb_addr_t NUM_OBJS_ADDR = 12'h800;

  function automatic waddr_t obj_addr(obj_cnt_t idx, logic [1:0] w);
    return waddr_t'((idx << OBJ_STRIDE_LOG2) | w);
  endfunction

endpackage

`default_nettype wire

// ==== hw/rt_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rt_top
  import rt_pkg::*;
#(
  parameter int MAX_OBJS = MAX_OBJS_DEF,
  parameter int MAX_BOUNCES = 4,
  parameter logic [31:0] SCATTER_SEED = 32'h1d2c3b4a
) (
  input logic clk,
  input logic rst,
  input logic psel,
  input logic penable,
  input logic pwrite,
  input apb_addr_t paddr,
  input word_t pwdata,
  output word_t prdata,
  output logic pready,
  output logic pslverr,
  input ray_req_t ray_in,
  input logic ray_valid,
  output logic ray_ready,
  output ray_res_t res,
  output logic res_valid
);
  logic a_req;
  logic a_we;
  waddr_t a_addr;
  word_t a_wdata;
  logic a_gnt;
  logic b_req;
  waddr_t b_addr;
  logic b_gnt;
  word_t rdata;
  obj_cnt_t num_objs;

  scene_apb_port #(
    .MAX_OBJS(MAX_OBJS)
  ) u_apb (
    .clk(clk),
    .rst(rst),
    .psel(psel),
    .penable(penable),
    .pwrite(pwrite),
    .paddr(paddr),
    .pwdata(pwdata),
    .prdata(prdata),
    .pready(pready),
    .pslverr(pslverr),
    .a_req(a_req),
    .a_we(a_we),
    .a_addr(a_addr),
    .a_wdata(a_wdata),
    .a_gnt(a_gnt),
    .rdata(rdata),
    .num_objs(num_objs)
  );

  scene_buffer #(
    .MAX_OBJS(MAX_OBJS)
  ) u_scene (
    .clk(clk),
    .rst(rst),
    .a_req(a_req),
    .a_we(a_we),
    .a_addr(a_addr),
    .a_wdata(a_wdata),
    .a_gnt(a_gnt),
    .b_req(b_req),
    .b_addr(b_addr),
    .b_gnt(b_gnt),
    .rdata(rdata)
  );

  ray_tracer #(
    .MAX_OBJS(MAX_OBJS),
    .MAX_BOUNCES(MAX_BOUNCES),
    .SCATTER_SEED(SCATTER_SEED)
  ) u_tracer (
    .clk(clk),
    .rst(rst),
    .ray_in(ray_in),
    .ray_valid(ray_valid),
    .ray_ready(ray_ready),
    .res(res),
    .res_valid(res_valid),
    .num_objs(num_objs),
    .b_req(b_req),
    .b_addr(b_addr),
    .b_gnt(b_gnt),
    .rdata(rdata)
  );

endmodule

`default_nettype wire

// ==== hw/scene_apb_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module scene_apb_port
  import rt_pkg::*;
#(
  parameter int MAX_OBJS = MAX_OBJS_DEF
) (
  input logic clk,
  input logic rst,
  input logic psel,
  input logic penable,
  input logic pwrite,
  input apb_addr_t paddr,
  input word_t pwdata,
  output word_t prdata,
  output logic pready,
  output logic pslverr,
  output logic a_req,
  output logic a_we,
  output waddr_t a_addr,
  output word_t a_wdata,
  input logic a_gnt,
  input word_t rdata,
  output obj_cnt_t num_objs
);
  logic access;
  logic scene_sel;
  logic cnt_sel;

  assign access = psel && penable;
  // Scene words fill the lower kilobyte
  assign scene_sel = (paddr[11:10] == 2'b00);
  assign cnt_sel = (paddr == NUM_OBJS_ADDR);

  // Request drops in the pready cycle so one access makes one grant
  assign a_req = access && scene_sel && !pready;
  assign a_we = pwrite;
  assign a_addr = paddr[9:2];
  assign a_wdata = pwdata;
  assign prdata = cnt_sel ? word_t'(num_objs) : rdata;

  always_ff @(posedge clk) begin
    if (rst) begin
      pready <= 1'b0;
      pslverr <= 1'b0;
      num_objs <= '0;
    end else begin
      pready <= 1'b0;
      pslverr <= 1'b0;
      if (access && !pready) begin
        if (scene_sel) begin
          pready <= a_gnt;
        end else if (cnt_sel) begin
          pready <= 1'b1;
          if (pwrite) begin
            num_objs <= (pwdata > word_t'(MAX_OBJS)) ? obj_cnt_t'(MAX_OBJS)
                                                     : obj_cnt_t'(pwdata);
          end
        end else begin
          // Unmapped
          pready <= 1'b1;
          pslverr <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/scene_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module scene_buffer
  import rt_pkg::*;
#(
  parameter int MAX_OBJS = MAX_OBJS_DEF
) (
  input logic clk,
  input logic rst,
  input logic a_req,
  input logic a_we,
  input waddr_t a_addr,
  input word_t a_wdata,
  output logic a_gnt,
  input logic b_req,
  input waddr_t b_addr,
  output logic b_gnt,
  output word_t rdata
);
  localparam int DEPTH = MAX_OBJS << OBJ_STRIDE_LOG2;
  localparam int AW = $clog2(DEPTH);

  word_t mem [DEPTH];
  // High when peer b won the last grant
  logic last_b;
  waddr_t gnt_addr;

  // A lone requester wins at once, a conflict goes to whoever waited
  assign a_gnt = a_req && (!b_req || last_b);
  assign b_gnt = b_req && (!a_req || !last_b);
  assign gnt_addr = a_gnt ? a_addr : b_addr;

  always_ff @(posedge clk) begin
    if (rst) begin
      last_b <= 1'b0;
    end else if (a_gnt || b_gnt) begin
      last_b <= b_gnt;
    end
  end

  // Single port, read data lands the cycle after the grant
  always_ff @(posedge clk) begin
    if (a_gnt && a_we) begin
      mem[a_addr[AW-1:0]] <= a_wdata;
    end
    if (a_gnt || b_gnt) begin
      rdata <= mem[gnt_addr[AW-1:0]];
    end
  end

  one_grant: assert property (@(posedge clk) disable iff (rst) !(a_gnt && b_gnt))
    else $error("both scene peers granted in one cycle");

  // A peer that loses a conflict must win on the next cycle
  a_no_starve: assert property (@(posedge clk) disable iff (rst) a_req && !a_gnt |=> a_gnt)
    else $error("APB peer lost arbitration twice");
  b_no_starve: assert property (@(posedge clk) disable iff (rst) b_req && !b_gnt |=> b_gnt)
    else $error("intersector lost arbitration twice");

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+sim
hw/rt_pkg.sv
hw/scene_buffer.sv
hw/scene_apb_port.sv
hw/ray_intersector.sv
hw/ray_reflector.sv
hw/ray_tracer.sv
hw/rt_top.sv
sim/tb_rt_top.sv

// ==== sim/rt_model.svh ====
`ifndef RT_MODEL_SVH
`define RT_MODEL_SVH

// Copy of every scene word written over APB
word_t model_mem [SCENE_WORDS];
int model_num_objs;
// Scatter generator, one step per reflection
logic [31:0] model_rng;

function automatic chan_t chan_mul(chan_t a, chan_t b);
  int p;
  p = int'(a) * int'(b);
  return chan_t'(p / 256);
endfunction

function automatic chan_t chan_add(chan_t a, chan_t b);
  int s;
  s = int'(a) + int'(b);
  return (s > 255) ? 8'd255 : chan_t'(s);
endfunction

function automatic sphere_t model_sphere(int i);
  sphere_t s;
  s.center = model_mem[4 * i][29:0];
  s.radius = model_mem[4 * i + 1][31:24];
  s.color = model_mem[4 * i + 1][23:0];
  s.emit = model_mem[4 * i + 2][23:0];
  return s;
endfunction

// Nearest centre among the hits, the first index wins a tie
function automatic bit nearest_hit(vec3_t org, dvec3_t d, output sphere_t hit);
  sphere_t s;
  longint lx;
  longint ly;
  longint lz;
  longint dx;
  longint dy;
  longint dz;
  longint b;
  longint dd;
  longint ll;
  longint r;
  longint best_ll;
  bit found;
  int i;
  found = 1'b0;
  best_ll = 0;
  hit = '0;
  for (i = 0; i < model_num_objs; i++) begin
    s = model_sphere(i);
    lx = longint'($signed(s.center.x)) - longint'($signed(org.x));
    ly = longint'($signed(s.center.y)) - longint'($signed(org.y));
    lz = longint'($signed(s.center.z)) - longint'($signed(org.z));
    dx = longint'($signed(d.x));
    dy = longint'($signed(d.y));
    dz = longint'($signed(d.z));
    r = longint'(s.radius);
    b = lx * dx + ly * dy + lz * dz;
    dd = dx * dx + dy * dy + dz * dz;
    ll = lx * lx + ly * ly + lz * lz;
    // Squared distance of the centre from the ray line, times |D|^2
    if (b > 0 && ll * dd - b * b <= r * r * dd && (!found || ll < best_ll)) begin
      found = 1'b1;
      best_ll = ll;
      hit = s;
    end
  end
  return found;
endfunction

function automatic rgb_t trace_ray(ray_req_t ray);
  vec3_t org;
  dvec3_t d;
  rgb_t color;
  rgb_t light;
  sphere_t s;
  int k;
  org = ray.origin;
  d = ray.dir;
  color = '1;
  light = '0;
  for (k = 0; k < MAX_BOUNCES; k++) begin
    if (!nearest_hit(org, d, s)) begin
      break;
    end
    // Emission is weighted by the colour the ray carried into the hit
    light.r = chan_add(light.r, chan_mul(color.r, s.emit.r));
    light.g = chan_add(light.g, chan_mul(color.g, s.emit.g));
    light.b = chan_add(light.b, chan_mul(color.b, s.emit.b));
    color.r = chan_mul(color.r, s.color.r);
    color.g = chan_mul(color.g, s.color.g);
    color.b = chan_mul(color.b, s.color.b);
    org = s.center;
    model_rng = xorshift32(model_rng);
    d.x = model_rng[7:0];
    d.y = model_rng[15:8];
    d.z = model_rng[23:16];
  end
  return light;
endfunction

`endif

// ==== sim/tb_rt_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rt_top
  import rt_pkg::*;
();
  localparam int CLK_PERIOD = 10;
  localparam int MAX_OBJS = 16;
  localparam int MAX_BOUNCES = 4;
  localparam logic [31:0] SCATTER_SEED = 32'h1d2c3b4a;
  localparam int SCENE_WORDS = MAX_OBJS * 4;
  localparam int EMPTY_RAYS = 4;
  localparam int SINGLE_RAYS = 3;
  localparam int RANDOM_RAYS = 50;
  localparam int LOAD_RAYS = 10;
  localparam int LOAD_READS = 20;
  localparam int TOTAL_RAYS = EMPTY_RAYS + SINGLE_RAYS + RANDOM_RAYS + LOAD_RAYS;
  localparam int RAY_TIMEOUT = MAX_BOUNCES * MAX_OBJS * 20;
  localparam int APB_TIMEOUT = 20;
  // Scene loading and APB traffic on top of the ray budget
  localparam longint WATCHDOG_CYCLES =
      longint'(TOTAL_RAYS) * MAX_BOUNCES * MAX_OBJS * 20 + 5000;

  logic clk;
  logic rst;
  logic psel;
  logic penable;
  logic pwrite;
  apb_addr_t paddr;
  word_t pwdata;
  word_t prdata;
  logic pready;
  logic pslverr;
  ray_req_t ray_in;
  logic ray_valid;
  logic ray_ready;
  ray_res_t res;
  logic res_valid;

  int checks;
  int errors;
  logic [31:0] stim_state;

  function automatic logic [31:0] xorshift32(logic [31:0] s);
    logic [31:0] t;
    t = s ^ (s << 13);
    t = t ^ (t >> 17);
    t = t ^ (t << 5);
    return t;
  endfunction

  function automatic logic [31:0] rand32();
    stim_state = xorshift32(stim_state);
    return stim_state;
  endfunction

  function automatic int rand_range(int lo, int hi);
    return lo + int'(rand32() % (hi - lo + 1));
  endfunction

  `include "rt_model.svh"

  rt_top #(
    .MAX_OBJS(MAX_OBJS),
    .MAX_BOUNCES(MAX_BOUNCES),
    .SCATTER_SEED(SCATTER_SEED)
  ) DUT (
    .clk(clk),
    .rst(rst),
    .psel(psel),
    .penable(penable),
    .pwrite(pwrite),
    .paddr(paddr),
    .pwdata(pwdata),
    .prdata(prdata),
    .pready(pready),
    .pslverr(pslverr),
    .ray_in(ray_in),
    .ray_valid(ray_valid),
    .ray_ready(ray_ready),
    .res(res),
    .res_valid(res_valid)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic apb_access(input logic wr, input apb_addr_t addr, input word_t wdata,
                            output word_t rdata, output logic err);
    int cycles;
    @(negedge clk);
    psel = 1'b1;
    penable = 1'b0;
    pwrite = wr;
    paddr = addr;
    pwdata = wdata;
    @(negedge clk);
    penable = 1'b1;
    cycles = 0;
    @(negedge clk);
    while (!pready && cycles < APB_TIMEOUT) begin
      cycles++;
      @(negedge clk);
    end
    if (!pready) begin
      $display("APB access to 0x%h never completed", addr);
      errors++;
    end
    rdata = prdata;
    err = pslverr;
    psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic write_scene_word(input int word, input word_t data);
    word_t rd;
    logic err;
    apb_access(1'b1, apb_addr_t'(word * 4), data, rd, err);
    model_mem[word] = data;
    if (err) begin
      $display("write to scene word %0d was refused with pslverr", word);
      errors++;
    end
  endtask

  task automatic read_expect(input apb_addr_t addr, input word_t exp);
    word_t rd;
    logic err;
    apb_access(1'b0, addr, '0, rd, err);
    checks++;
    if (rd !== exp) begin
      $display("CHECK FAILED prdata at 0x%h: got 0x%h expected 0x%h", addr, rd, exp);
      errors++;
    end
  endtask

  task automatic set_num_objs(input int n);
    word_t rd;
    logic err;
    apb_access(1'b1, NUM_OBJS_ADDR, word_t'(n), rd, err);
    model_num_objs = (n > MAX_OBJS) ? MAX_OBJS : n;
  endtask

  task automatic load_sphere(input int i, input sphere_t s);
    write_scene_word(4 * i, {2'b00, s.center});
    write_scene_word(4 * i + 1, {s.radius, s.color});
    write_scene_word(4 * i + 2, {8'h00, s.emit});
  endtask

  function automatic sphere_t random_sphere();
    sphere_t s;
    logic [31:0] w;
    s.center.x = coord_t'(rand_range(-200, 200));
    s.center.y = coord_t'(rand_range(-200, 200));
    s.center.z = coord_t'(rand_range(60, 400));
    s.radius = 8'(rand_range(15, 90));
    w = rand32();
    s.color = w[23:0];
    w = rand32();
    s.emit = w[23:0];
    return s;
  endfunction

  // Rays start near the origin and mostly head down +z into the scene
  function automatic ray_req_t random_ray();
    ray_req_t r;
    r.origin.x = coord_t'(rand_range(-60, 60));
    r.origin.y = coord_t'(rand_range(-60, 60));
    r.origin.z = coord_t'(rand_range(-20, 20));
    r.dir.x = dir_t'(rand_range(-50, 50));
    r.dir.y = dir_t'(rand_range(-50, 50));
    r.dir.z = dir_t'(rand_range(10, 127));
    r.pixel.h = 11'(rand32());
    r.pixel.v = 10'(rand32());
    return r;
  endfunction

  task automatic send_ray(input ray_req_t r, output ray_res_t got, output logic ok);
    int cycles;
    ok = 1'b0;
    got = '0;
    cycles = 0;
    @(negedge clk);
    while (!ray_ready && cycles < RAY_TIMEOUT) begin
      cycles++;
      @(negedge clk);
    end
    if (!ray_ready) begin
      $display("ray for pixel 0x%h was never accepted", r.pixel);
      errors++;
      return;
    end
    ray_in = r;
    ray_valid = 1'b1;
    @(negedge clk);
    ray_valid = 1'b0;
    cycles = 0;
    while (!res_valid && cycles < RAY_TIMEOUT) begin
      cycles++;
      @(negedge clk);
    end
    if (!res_valid) begin
      $display("no result came back for pixel 0x%h", r.pixel);
      errors++;
      return;
    end
    got = res;
    ok = 1'b1;
  endtask

  task automatic check_ray(input ray_req_t r);
    rgb_t exp;
    ray_res_t got;
    logic ok;
    exp = trace_ray(r);
    send_ray(r, got, ok);
    if (ok) begin
      checks++;
      if (got.pixel !== r.pixel) begin
        $display("CHECK FAILED res.pixel: got 0x%h expected 0x%h", got.pixel, r.pixel);
        errors++;
      end
      if (got.color !== exp) begin
        $display("CHECK FAILED res.color for pixel 0x%h: got 0x%h expected 0x%h",
                 r.pixel, got.color, exp);
        errors++;
      end
    end
  endtask

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, the run is stuck", WATCHDOG_CYCLES);
    $display("** FAIL **");
    $finish;
  end

  initial begin
    int err_before;
    int i;
    int n;
    int words[$];
    ray_req_t rays[$];
    apb_addr_t reads[$];
    sphere_t s;
    ray_req_t r;
    word_t rd;
    logic err;
    clk = 1'b0;
    rst = 1'b1;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    ray_in = '0;
    ray_valid = 1'b0;
    checks = 0;
    errors = 0;
    stim_state = 32'h2345fc8c;
    model_rng = SCATTER_SEED;
    model_num_objs = 0;
    repeat (5) @(negedge clk);
    rst = 1'b0;

    err_before = errors;
    for (i = 0; i < 12; i++) begin
      words.push_back(rand_range(0, SCENE_WORDS - 1));
      write_scene_word(words[i], rand32());
    end
    foreach (words[k]) begin
      read_expect(apb_addr_t'(words[k] * 4), model_mem[words[k]]);
    end
    n = rand_range(0, MAX_OBJS);
    set_num_objs(n);
    read_expect(NUM_OBJS_ADDR, word_t'(n));
    set_num_objs(MAX_OBJS + rand_range(1, 1000));
    read_expect(NUM_OBJS_ADDR, word_t'(MAX_OBJS));
    apb_access(1'b0, apb_addr_t'(12'h400 + 4 * rand_range(0, 255)), '0, rd, err);
    checks++;
    if (err !== 1'b1) begin
      $display("CHECK FAILED pslverr on unmapped read: got 0x%h expected 0x1", err);
      errors++;
    end
    $display("test 1 APB round trip: %0d errors", errors - err_before);

    err_before = errors;
    set_num_objs(0);
    for (i = 0; i < EMPTY_RAYS; i++) begin
      check_ray(random_ray());
      @(negedge clk);
      checks++;
      if (ray_ready !== 1'b1) begin
        $display("CHECK FAILED ray_ready after result: got 0x%h expected 0x1", ray_ready);
        errors++;
      end
    end
    $display("test 2 empty scene: %0d errors", errors - err_before);

    err_before = errors;
    s.center = '{x: 10'sd0, y: 10'sd0, z: 10'sd200};
    s.radius = 8'd40;
    s.color = '{r: 8'd200, g: 8'd150, b: 8'd100};
    s.emit = '{r: 8'd240, g: 8'd120, b: 8'd60};
    load_sphere(0, s);
    set_num_objs(1);
    for (i = 0; i < SINGLE_RAYS; i++) begin
      r = random_ray();
      r.origin = '0;
      r.dir = '{x: 8'sd0, y: 8'sd0, z: dir_t'(rand_range(16, 127))};
      check_ray(r);
    end
    $display("test 3 single emitting sphere: %0d errors", errors - err_before);

    err_before = errors;
    for (i = 0; i < 8; i++) begin
      load_sphere(i, random_sphere());
    end
    set_num_objs(8);
    for (i = 0; i < RANDOM_RAYS; i++) begin
      check_ray(random_ray());
    end
    $display("test 4 random scenes: %0d errors", errors - err_before);

    // Stimulus is drawn up front so both processes see a fixed order
    err_before = errors;
    for (i = 0; i < LOAD_RAYS; i++) begin
      rays.push_back(random_ray());
    end
    for (i = 0; i < LOAD_READS; i++) begin
      reads.push_back(apb_addr_t'((4 * rand_range(0, 7) + rand_range(0, 2)) * 4));
    end
    fork
      begin
        foreach (rays[k]) begin
          check_ray(rays[k]);
        end
      end
      begin
        foreach (reads[k]) begin
          read_expect(reads[k], model_mem[reads[k] >> 2]);
        end
      end
    join
    $display("test 5 arbitration under load: %0d errors", errors - err_before);

    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire
